// File: lsu_pkg.sv
package lsu_pkg;

    localparam int SB_DEPTH  = 8;
    localparam int MEM_WORDS = 256;                   // 32-bit words
    localparam int SB_IDX_W  = $clog2(SB_DEPTH);
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    typedef logic [31:0] addr_t;                      // Byte address
    typedef logic [5:0]  tag_t;                       // ROB instruction tag
    typedef logic [7:0]  preg_t;                      // Physical register

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    // funct3 of loads and stores, bit 2 is the unsigned flag for loads only
    typedef union packed {
        logic [2:0] raw;
        struct packed {
            logic      is_unsigned;
            mem_size_e size;
        } f;
    } mem_funct_u;

    typedef struct packed {
        logic        valid;
        tag_t        tag;
        addr_t       addr;
        logic [31:0] data;                            // Low-aligned rs2 value
        mem_funct_u  funct;
    } store_req_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        preg_t      rd;
        addr_t      addr;
        mem_funct_u funct;
    } load_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } commit_t;

    typedef struct packed {
        logic        done;
        tag_t        tag;
        preg_t       rd;
        logic [31:0] data;
        logic        forwarded;
    } load_result_t;

    typedef struct packed {
        logic                 valid;
        logic [MEM_IDX_W-1:0] index;
        logic [31:0]          data;                   // Already in byte lanes
        logic [3:0]           be;
    } mem_wr_t;

endpackage

// File: store_buffer.sv
`timescale 1ns/1ps

module store_buffer import lsu_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  store_req_t  store,
    input  commit_t     commit,
    input  logic        lookup_valid,
    input  addr_t       lookup_addr,
    input  mem_funct_u  lookup_funct,
    output logic        fwd_hit,
    output logic [31:0] fwd_data,
    output mem_wr_t     mem_wr,
    output logic        full
);

    typedef struct packed {
        tag_t        tag;
        addr_t       addr;
        logic [31:0] data;                            // Truncated to size
        mem_size_e   size;
    } sb_entry_t;

    logic [SB_DEPTH-1:0] valid_q;
    logic [SB_DEPTH-1:0] valid_d;
    sb_entry_t           entry_q [SB_DEPTH];
    sb_entry_t           st_entry;

    logic [SB_DEPTH-1:0] st_match;
    logic [SB_DEPTH-1:0] cm_match;
    logic [SB_DEPTH-1:0] lk_match;
    logic [SB_DEPTH-1:0] free_slots;
    logic                alloc_ok;
    logic [SB_IDX_W-1:0] alloc_idx;
    logic                cm_found;
    logic [SB_IDX_W-1:0] cm_idx;
    logic                lk_found;
    logic [SB_IDX_W-1:0] lk_idx;

    function automatic logic [31:0] truncate(input logic [31:0] d, input mem_size_e size);
        case (size)
            SIZE_BYTE: return {24'h0, d[7:0]};
            SIZE_HALF: return {16'h0, d[15:0]};
            default:   return d;
        endcase
    endfunction

    // Moves the low-aligned data up to the lanes its address selects
    function automatic logic [31:0] place_lanes(input sb_entry_t e);
        return e.data << {e.addr[1:0], 3'b000};
    endfunction

    function automatic logic [3:0] byte_en(input mem_size_e size, input logic [1:0] off);
        case (size)
            SIZE_BYTE: return 4'b0001 << off;
            SIZE_HALF: return 4'b0011 << off;
            default:   return 4'b1111;
        endcase
    endfunction

    always_comb begin
        for (int i = 0; i < SB_DEPTH; i++) begin
            st_match[i] = valid_q[i] && (entry_q[i].addr == store.addr);
            cm_match[i] = valid_q[i] && (entry_q[i].tag == commit.tag);
            lk_match[i] = valid_q[i] && (entry_q[i].addr == lookup_addr)
                          && (entry_q[i].size >= lookup_funct.f.size);
        end
    end

    assign free_slots = ~valid_q | st_match;          // Replaced entry counts as free

    // Lowest index wins in all three searches
    always_comb begin
        alloc_ok  = 1'b0;
        alloc_idx = '0;
        cm_found  = 1'b0;
        cm_idx    = '0;
        lk_found  = 1'b0;
        lk_idx    = '0;
        for (int i = SB_DEPTH - 1; i >= 0; i--) begin
            if (free_slots[i]) begin
                alloc_ok  = 1'b1;
                alloc_idx = SB_IDX_W'(i);
            end
            if (cm_match[i]) begin
                cm_found = 1'b1;
                cm_idx   = SB_IDX_W'(i);
            end
            if (lk_match[i]) begin
                lk_found = 1'b1;
                lk_idx   = SB_IDX_W'(i);
            end
        end
    end

    // Commit drains straight to memory so the write lands on the commit edge
    always_comb begin
        mem_wr.valid = commit.valid && cm_found && !flush;
        mem_wr.index = entry_q[cm_idx].addr[MEM_IDX_W+1:2];
        mem_wr.data  = place_lanes(entry_q[cm_idx]);
        mem_wr.be    = byte_en(entry_q[cm_idx].size, entry_q[cm_idx].addr[1:0]);
    end

    always_comb begin
        st_entry.tag  = store.tag;
        st_entry.addr = store.addr;
        st_entry.data = truncate(store.data, store.funct.f.size);
        st_entry.size = store.funct.f.size;
    end

    always_comb begin
        valid_d = valid_q;
        if (store.valid) begin
            valid_d = valid_d & ~st_match;            // Drop older same-address entry
        end
        if (mem_wr.valid) begin
            valid_d[cm_idx] = 1'b0;
        end
        if (store.valid && alloc_ok) begin
            valid_d[alloc_idx] = 1'b1;
        end
        if (flush) begin
            valid_d = '0;                             // Exception or mret
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        if (store.valid && alloc_ok) begin
            entry_q[alloc_idx] <= st_entry;
        end
    end

    // Lookup sees the state before this cycle's updates
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fwd_hit <= 1'b0;
        end else begin
            fwd_hit <= lookup_valid && lk_found;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_valid) begin
            fwd_data <= place_lanes(entry_q[lk_idx]);
        end
    end

    assign full = &valid_q;

endmodule

// File: data_memory.sv
`timescale 1ns/1ps

module data_memory import lsu_pkg::*; (
    input  logic                 clk,
    input  logic                 rd_en,
    input  logic [MEM_IDX_W-1:0] rd_index,
    input  mem_wr_t              wr,
    output logic [31:0]          rd_data
);

    logic [31:0] mem [MEM_WORDS];

    // Read before write on a same-index collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            for (int b = 0; b < 4; b++) begin
                if (wr.be[b]) begin
                    mem[wr.index][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: load_align_extend.sv
`timescale 1ns/1ps

module load_align_extend import lsu_pkg::*; (
    input  logic        fwd_hit,
    input  logic [31:0] fwd_data,
    input  logic [31:0] mem_data,
    input  logic [1:0]  byte_offset,
    input  mem_funct_u  funct,
    output logic [31:0] data
);

    logic [31:0] src_word;
    logic [31:0] shifted;
    logic        byte_fill;
    logic        half_fill;

    // Both sources hold the data in its own byte lanes
    assign src_word = fwd_hit ? fwd_data : mem_data;
    assign shifted  = src_word >> {byte_offset, 3'b000};

    assign byte_fill = !funct.f.is_unsigned && shifted[7];
    assign half_fill = !funct.f.is_unsigned && shifted[15];

    always_comb begin
        case (funct.f.size)
            SIZE_BYTE: data = {{24{byte_fill}}, shifted[7:0]};   // LB, LBU
            SIZE_HALF: data = {{16{half_fill}}, shifted[15:0]};  // LH, LHU
            default:   data = shifted;                           // LW
        endcase
    end

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps

module lsu_top import lsu_pkg::*; (
    input  logic         clk,
    input  logic         arst_n,
    input  logic         flush,
    input  store_req_t   store,
    input  load_req_t    load,
    input  commit_t      commit,
    output load_result_t result,
    output logic         sb_full
);

    typedef struct packed {
        tag_t       tag;
        preg_t      rd;
        logic [1:0] offset;
        mem_funct_u funct;
    } ld_side_t;

    logic        ld_valid_q;
    ld_side_t    ld_q;
    logic        fwd_hit;
    logic [31:0] fwd_data;
    mem_wr_t     mem_wr;
    logic [31:0] mem_rd_data;
    logic [31:0] ld_data;

    store_buffer u_store_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .flush        (flush),
        .store        (store),
        .commit       (commit),
        .lookup_valid (load.valid),
        .lookup_addr  (load.addr),
        .lookup_funct (load.funct),
        .fwd_hit      (fwd_hit),
        .fwd_data     (fwd_data),
        .mem_wr       (mem_wr),
        .full         (sb_full)
    );

    data_memory u_data_memory (
        .clk      (clk),
        .rd_en    (load.valid),
        .rd_index (load.addr[MEM_IDX_W+1:2]),
        .wr       (mem_wr),
        .rd_data  (mem_rd_data)
    );

    load_align_extend u_load_align_extend (
        .fwd_hit     (fwd_hit),
        .fwd_data    (fwd_data),
        .mem_data    (mem_rd_data),
        .byte_offset (ld_q.offset),
        .funct       (ld_q.funct),
        .data        (ld_data)
    );

    // Sideband follows the buffer lookup and memory read by one cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ld_valid_q <= 1'b0;
        end else begin
            ld_valid_q <= load.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load.valid) begin
            ld_q.tag    <= load.tag;
            ld_q.rd     <= load.rd;
            ld_q.offset <= load.addr[1:0];
            ld_q.funct  <= load.funct;
        end
    end

    always_comb begin
        result.done      = ld_valid_q;
        result.tag       = ld_q.tag;
        result.rd        = ld_q.rd;
        result.data      = ld_data;
        result.forwarded = fwd_hit;                   // Low when no load was looked up
    end

endmodule

// File: lsu_properties.sv
`timescale 1ns/1ps

module lsu_properties import lsu_pkg::*; (
    input logic         clk,
    input logic         arst_n,
    input logic         flush,
    input store_req_t   store,
    input load_req_t    load,
    input load_result_t result,
    input mem_wr_t      mem_wr,
    input logic         sb_full
);

    int fail_count = 0;                               // Read by the testbench

    function automatic logic aligned(input addr_t addr, input mem_funct_u funct);
        case (funct.f.size)
            SIZE_HALF: return addr[0] == 1'b0;
            SIZE_WORD: return addr[1:0] == 2'b00;
            default:   return 1'b1;
        endcase
    endfunction

    done_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        load.valid |=> result.done) else begin
        $error("result.done missing one cycle after load.valid");
        fail_count++;
    end

    done_needs_load: assert property (@(posedge clk) disable iff (!arst_n)
        result.done |-> $past(load.valid)) else begin
        $error("result.done without a load one cycle earlier");
        fail_count++;
    end

    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !result.done && !mem_wr.valid) else begin
        $error("result.done or memory write during reset");
        fail_count++;
    end

    no_store_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        store.valid |-> !sb_full) else begin
        $error("store issued while the store buffer is full");
        fail_count++;
    end

    aligned_access: assert property (@(posedge clk) disable iff (!arst_n)
        (!load.valid || aligned(load.addr, load.funct))
        && (!store.valid || aligned(store.addr, store.funct))) else begin
        $error("misaligned load or store");
        fail_count++;
    end

    empty_after_flush: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !sb_full) else begin
        $error("sb_full high the cycle after flush");
        fail_count++;
    end

endmodule

bind lsu_top lsu_properties u_props (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (flush),
    .store   (store),
    .load    (load),
    .result  (result),
    .mem_wr  (mem_wr),
    .sb_full (sb_full)
);

// File: tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu import lsu_pkg::*; ();

    typedef struct packed {
        logic [31:0] data;
        logic        fwd;
        tag_t        tag;
        preg_t       rd;
    } exp_t;

    logic         clk;
    logic         arst_n;
    logic         flush;
    store_req_t   store;
    load_req_t    load;
    commit_t      commit;
    load_result_t result;
    logic         sb_full;

    logic [31:0] smem [MEM_WORDS];                    // Shadow data memory
    logic        m_valid [SB_DEPTH];                  // Shadow store buffer
    tag_t        m_tag [SB_DEPTH];
    addr_t       m_addr [SB_DEPTH];
    logic [31:0] m_data [SB_DEPTH];
    logic [1:0]  m_size [SB_DEPTH];
    exp_t        exp_q [$];
    tag_t        next_tag;
    int          seed = 59567;
    string       test_name;

    lsu_top DUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .store   (store),
        .load    (load),
        .commit  (commit),
        .result  (result),
        .sb_full (sb_full)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("ERROR [%s] %s", test_name, msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            $display("CHECK FAILED [%s] %s expected %h actual %h", test_name, what, exp, act);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    function automatic int buffered_count();
        int n;
        n = 0;
        for (int i = 0; i < SB_DEPTH; i++) begin
            n += int'(m_valid[i]);
        end
        return n;
    endfunction

    function automatic logic tag_in_use(input tag_t tag);
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (m_valid[i] && m_tag[i] == tag) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    function automatic tag_t tag_of(input addr_t addr);
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (m_valid[i] && m_addr[i] == addr) begin
                return m_tag[i];
            end
        end
        return '0;
    endfunction

    function automatic tag_t random_buffered_tag();
        int k;
        k = $random(seed) & 7;
        for (int n = 0; n < SB_DEPTH; n++) begin
            if (m_valid[(k + n) % SB_DEPTH]) begin
                return m_tag[(k + n) % SB_DEPTH];
            end
        end
        return '0;
    endfunction

    // Eight words at 0x40, offset aligned to the access size
    function automatic addr_t rand_addr(input logic [2:0] f3);
        addr_t a;
        a = 32'h40 + 32'(($random(seed) & 7) * 4);
        case (f3[1:0])
            2'd0:    a[1:0] = 2'($random(seed));
            2'd1:    a[1:0] = {1'($random(seed)), 1'b0};
            default: a[1:0] = 2'b00;
        endcase
        return a;
    endfunction

    function automatic logic [2:0] rand_load_f3();
        logic [2:0] f3;
        do begin
            f3 = 3'($random(seed));
        end while (f3 == 3'd3 || f3 > 3'd5);              // LB LH LW LBU LHU
        return f3;
    endfunction

    function automatic logic [2:0] rand_store_f3();
        logic [2:0] f3;
        do begin
            f3 = {1'b0, 2'($random(seed))};
        end while (f3 == 3'd3);
        return f3;
    endfunction

    function automatic logic [31:0] extend_load(input logic [31:0] w, input logic [2:0] f3);
        case (f3)
            3'b000:  return {{24{w[7]}}, w[7:0]};
            3'b001:  return {{16{w[15]}}, w[15:0]};
            3'b100:  return {24'h0, w[7:0]};
            3'b101:  return {16'h0, w[15:0]};
            default: return w;
        endcase
    endfunction

    // Forwarding needs the same byte address and a store at least as wide
    function automatic exp_t expect_load(input load_req_t ld);
        exp_t        e;
        logic [31:0] word;
        e.fwd = 1'b0;
        e.tag = ld.tag;
        e.rd  = ld.rd;
        word  = smem[ld.addr[MEM_IDX_W+1:2]];
        for (int i = 0; i < SB_DEPTH; i++) begin
            if (m_valid[i] && m_addr[i] == ld.addr && m_size[i] >= ld.funct.raw[1:0]) begin
                e.fwd = 1'b1;
                word  = m_data[i] << (8 * ld.addr[1:0]);
            end
        end
        e.data = extend_load(word >> (8 * ld.addr[1:0]), ld.funct.raw);
        return e;
    endfunction

    task automatic write_shadow(input int i);
        logic [MEM_IDX_W-1:0] w;
        int                   off;
        w   = m_addr[i][MEM_IDX_W+1:2];
        off = 8 * m_addr[i][1:0];
        case (m_size[i])
            2'd0:    smem[w][off +: 8] = m_data[i][7:0];
            2'd1:    smem[w][off +: 16] = m_data[i][15:0];
            default: smem[w] = m_data[i];
        endcase
    endtask

    task automatic update_model();
        int slot;
        if (flush) begin
            foreach (m_valid[i]) begin
                m_valid[i] = 1'b0;
            end
        end else begin
            for (int i = 0; i < SB_DEPTH; i++) begin
                if (commit.valid && m_valid[i] && m_tag[i] == commit.tag) begin
                    write_shadow(i);
                    m_valid[i] = 1'b0;
                end
                if (store.valid && m_valid[i] && m_addr[i] == store.addr) begin
                    m_valid[i] = 1'b0;                // Older same-address store replaced
                end
            end
            if (store.valid) begin
                slot = 0;
                for (int i = SB_DEPTH - 1; i >= 0; i--) begin
                    if (!m_valid[i]) begin
                        slot = i;
                    end
                end
                m_valid[slot] = 1'b1;
                m_tag[slot]   = store.tag;
                m_addr[slot]  = store.addr;
                m_size[slot]  = store.funct.raw[1:0];
                m_data[slot]  = store.data & (store.funct.raw[1:0] == 2'd0 ? 32'hff :
                                store.funct.raw[1:0] == 2'd1 ? 32'hffff : 32'hffff_ffff);
            end
        end
    endtask

    task automatic check_outputs();
        exp_t e;
        if (DUT.u_props.fail_count != 0) begin
            report_failure("a bound property failed");
        end
        if (result.done) begin
            if (exp_q.size() == 0) begin
                report_failure("result.done without a pending load");
            end else begin
                e = exp_q.pop_front();
                check_value("load data", e.data, result.data);
                check_value("forwarded", 32'(e.fwd), 32'(result.forwarded));
                check_value("tag", 32'(e.tag), 32'(result.tag));
                check_value("rd", 32'(e.rd), 32'(result.rd));
            end
        end else if (exp_q.size() != 0) begin
            report_failure("result.done missing one cycle after the load");
        end
        check_value("sb_full", 32'(buffered_count() == SB_DEPTH), 32'(sb_full));
    endtask

    // One cycle: model the driven inputs, then check outputs at the next falling edge
    task automatic tick();
        if (load.valid) begin
            exp_q.push_back(expect_load(load));
        end
        update_model();
        @(posedge clk);
        @(negedge clk);
        check_outputs();
        store  = '0;
        load   = '0;
        commit = '0;
        flush  = 1'b0;
    endtask

    task automatic issue_store(input addr_t addr, input logic [31:0] data, input logic [2:0] f3);
        while (tag_in_use(next_tag)) begin
            next_tag++;
        end
        store.valid     = 1'b1;
        store.tag       = next_tag;
        store.addr      = addr;
        store.data      = data;
        store.funct.raw = f3;
        next_tag++;
    endtask

    task automatic issue_load(input addr_t addr, input logic [2:0] f3);
        load.valid     = 1'b1;
        load.tag       = 6'($random(seed));
        load.rd        = 8'($random(seed));
        load.addr      = addr;
        load.funct.raw = f3;
    endtask

    task automatic issue_commit(input tag_t tag);
        commit.valid = 1'b1;
        commit.tag   = tag;
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || result.done) begin
            if (cycles == 10) begin
                report_failure("timeout waiting for load results");
            end
            tick();
            cycles++;
        end
    endtask

    initial begin
        addr_t       a;
        logic [2:0]  f3;
        logic [31:0] r;
        arst_n    = 1'b0;
        flush     = 1'b0;
        store     = '0;
        load      = '0;
        commit    = '0;
        next_tag  = '0;
        test_name = "reset";
        foreach (m_valid[i]) begin
            m_valid[i] = 1'b0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        test_name = "memory_fill";                    // Every word read later
        for (int w = 0; w < 8; w++) begin
            issue_store(32'h40 + 32'(4 * w), $random(seed), 3'b010);
            tick();
            issue_commit(tag_of(32'h40 + 32'(4 * w)));
            tick();
        end
        test_name = "memory_path";
        for (int n = 0; n < 20; n++) begin
            f3 = rand_load_f3();
            issue_load(rand_addr(f3), f3);
            tick();
        end
        test_name = "forwarding";
        for (int n = 0; n < 6; n++) begin
            f3 = rand_store_f3();
            a  = rand_addr(f3);
            issue_store(a, $random(seed), f3);
            tick();
            issue_load(a, f3);
            tick();
            issue_store(a, $random(seed), f3);
            tick();
            issue_load(a, 3'b100);                    // LBU sees the newer store
            tick();
            issue_commit(tag_of(a));
            tick();
        end
        test_name = "commit_drain";
        for (int n = 0; n < 6; n++) begin
            f3 = 3'(n % 2);
            a  = rand_addr(f3);
            issue_store(a, $random(seed), f3);
            tick();
            issue_commit(tag_of(a));
            issue_load(a, f3);                        // Still forwards
            tick();
            issue_load({a[31:2], 2'b00}, 3'b010);
            tick();
        end
        test_name = "flush";
        for (int w = 0; w < 3; w++) begin
            issue_store(32'h40 + 32'(4 * w), $random(seed), 3'b010);
            tick();
        end
        flush = 1'b1;
        issue_load(32'h40, 3'b010);
        tick();
        for (int w = 0; w < 3; w++) begin
            issue_load(32'h40 + 32'(4 * w), 3'b010);
            tick();
        end
        test_name = "capacity";
        for (int w = 0; w < SB_DEPTH; w++) begin
            issue_store(32'h40 + 32'(4 * w), $random(seed), 3'b010);
            tick();
        end
        issue_commit(tag_of(32'h40));
        tick();
        issue_store(32'h40, $random(seed), 3'b010);   // Full again
        tick();
        flush = 1'b1;
        tick();
        test_name = "random";
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            if (r[0] && buffered_count() < SB_DEPTH) begin
                f3 = rand_store_f3();
                issue_store(rand_addr(f3), $random(seed), f3);
            end
            if (r[1]) begin
                f3 = rand_load_f3();
                issue_load(rand_addr(f3), f3);
            end
            if (r[2] && buffered_count() != 0) begin
                issue_commit(random_buffered_tag());
            end
            flush = (r[7:3] == 5'd0);
            tick();
        end
        wait_idle();

        if (DUT.u_props.fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: tb.f
lsu_pkg.sv
store_buffer.sv
data_memory.sv
load_align_extend.sv
lsu_top.sv
lsu_properties.sv
tb_lsu.sv

// File: Bender.yml
package:
  name: lsu

sources:
  - lsu_pkg.sv
  - store_buffer.sv
  - data_memory.sv
  - load_align_extend.sv
  - lsu_top.sv
  - target: test
    files:
      - lsu_properties.sv
      - tb_lsu.sv
